//--- logic/melody_sequencer.sv
module melody_sequencer
    import music_pkg::*, tone_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic                                 play_req,
    output logic                                 play_ack,
    output logic                                 busy,
    output logic [num_voices-1:0][note_w-1:0]    note_code,
    output logic [num_voices-1:0]                note_load
);

    logic [1:0]         state;
    logic [idx_w-1:0]   idx;
    logic [tick_w-1:0]  tick_cnt;

    logic [idx_w-1:0]   nxt_idx;
    melody_entry_t      nxt_entry;
    logic [steps_w-1:0] nxt_steps;
    logic [tick_w-1:0]  nxt_ticks;
    logic               is_note;
    logic               is_end;

    logic take_entry;
    logic abort;
    logic release_ack;

    assign busy     = (state == seq_play);
    assign play_ack = (state == seq_ack);

    // entry 0 on start, otherwise the one after the current
    assign nxt_idx   = (state == seq_idle) ? '0 : idx + 1'b1;
    assign nxt_entry = melody[nxt_idx];

    // kind bit sits at the top of both views
    assign is_note = (nxt_entry.note.kind == kind_note);
    assign is_end  = !is_note && (nxt_entry.ctrl.op == op_end);

    always_comb begin
        if (is_note) begin
            nxt_steps = nxt_entry.note.steps;
        end else begin
            nxt_steps = nxt_entry.ctrl.steps;
        end
    end

    assign nxt_ticks = tick_w'(nxt_steps) * tick_w'(step_ticks) - 1'b1;

    assign take_entry = play_req &&
                        ((state == seq_idle) || (state == seq_play && tick_cnt == '0));
    assign abort       = (state == seq_play) && !play_req;
    assign release_ack = (state == seq_ack) && !play_req;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= seq_idle;
            idx       <= '0;
            tick_cnt  <= '0;
            note_code <= '0;
            note_load <= '0;
        end else begin
            note_load <= '0;
            if (abort) begin
                state     <= seq_idle;
                note_code <= '0;
            end else if (release_ack) begin
                state <= seq_idle;
            end else if (take_entry) begin
                idx      <= nxt_idx;
                tick_cnt <= nxt_ticks;
                if (is_note) begin
                    state                           <= seq_play;
                    note_code[nxt_entry.note.voice] <= nxt_entry.note.code;
                    // pulse even for a repeated note so its divider restarts
                    note_load[nxt_entry.note.voice] <= 1'b1;
                end else if (is_end) begin
                    state     <= seq_ack;
                    note_code <= '0;
                end else begin
                    // rest, voices keep what they have
                    state <= seq_play;
                end
            end else if (state == seq_play) begin
                tick_cnt <= tick_cnt - 1'b1;
            end
        end
    end

    a_ack_not_busy: assert property (@(posedge clk) disable iff (!arst_n)
        play_ack |-> !busy);

    a_load_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(note_load));

endmodule

//--- logic/music_box.sv
module music_box
    import music_pkg::*, tone_pkg::*;
(
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              play_req,
    output logic                              play_ack,
    output logic                              busy,
    output logic [num_voices-1:0][note_w-1:0] voice_notes,
    output logic [1:0]                        level
);

    logic [num_voices-1:0] note_load;
    logic [num_voices-1:0] wave;

    melody_sequencer u_seq (
        .clk       (clk),
        .arst_n    (arst_n),
        .play_req  (play_req),
        .play_ack  (play_ack),
        .busy      (busy),
        .note_code (voice_notes),
        .note_load (note_load)
    );

    // one divider per voice, each watching its own note register
    for (genvar v = 0; v < num_voices; v++) begin : g_voice
        tone_voice u_voice (
            .clk       (clk),
            .arst_n    (arst_n),
            .note_code (voice_notes[v]),
            .note_load (note_load[v]),
            .wave      (wave[v])
        );
    end

    voice_mixer u_mix (
        .clk    (clk),
        .arst_n (arst_n),
        .wave   (wave),
        .level  (level)
    );

endmodule

//--- logic/music_pkg.sv
package music_pkg;

    import tone_pkg::*;

    localparam int num_voices = 3;
    localparam int step_ticks = 16;
    localparam int melody_len = 24;

    localparam int voice_w = 2;
    localparam int steps_w = 5;
    localparam int idx_w   = $clog2(melody_len);
    // longest entry is (2**steps_w - 1) steps
    localparam int tick_w  = $clog2((2**steps_w) * step_ticks);

    localparam logic kind_note = 1'b0;
    localparam logic kind_ctrl = 1'b1;

    localparam logic [1:0] op_rest = 2'd0;
    localparam logic [1:0] op_end  = 2'd1;

    // sequencer state codes
    localparam logic [1:0] seq_idle = 2'd0;
    localparam logic [1:0] seq_play = 2'd1;
    localparam logic [1:0] seq_ack  = 2'd2;

    typedef struct packed {
        logic               kind;
        logic [voice_w-1:0] voice;
        logic [note_w-1:0]  code;
        logic [steps_w-1:0] steps;
    } note_view_t;

    typedef struct packed {
        logic               kind;
        logic [1:0]         op;
        logic [steps_w-1:0] steps;
        logic [note_w-1:0]  pad;
    } ctrl_view_t;

    typedef union packed {
        note_view_t note;
        ctrl_view_t ctrl;
    } melody_entry_t;

    function automatic melody_entry_t note_entry(input logic [voice_w-1:0] voice,
                                                 input logic [note_w-1:0] code,
                                                 input logic [steps_w-1:0] steps);
        melody_entry_t e;
        e.note.kind  = kind_note;
        e.note.voice = voice;
        e.note.code  = code;
        e.note.steps = steps;
        return e;
    endfunction

    function automatic melody_entry_t ctrl_entry(input logic [1:0] op,
                                                 input logic [steps_w-1:0] steps);
        melody_entry_t e;
        e.ctrl.kind  = kind_ctrl;
        e.ctrl.op    = op;
        e.ctrl.steps = steps;
        e.ctrl.pad   = '0;
        return e;
    endfunction

    // voice 0 carries the tune, 1 and 2 fill in underneath
    localparam melody_entry_t melody [melody_len] = '{
        note_entry(2'd0, 4'd11, 5'd2),
        note_entry(2'd1, 4'd6,  5'd2),
        note_entry(2'd0, 4'd10, 5'd1),
        note_entry(2'd0, 4'd9,  5'd1),
        note_entry(2'd2, 4'd4,  5'd2),
        note_entry(2'd0, 4'd10, 5'd1),
        note_entry(2'd0, 4'd11, 5'd1),
        ctrl_entry(op_rest, 5'd2),
        note_entry(2'd0, 4'd10, 5'd2),
        note_entry(2'd1, 4'd9,  5'd2),
        note_entry(2'd2, 4'd0,  5'd1),
        note_entry(2'd0, 4'd8,  5'd1),
        note_entry(2'd0, 4'd7,  5'd1),
        note_entry(2'd0, 4'd8,  5'd2),
        note_entry(2'd1, 4'd8,  5'd1),
        note_entry(2'd2, 4'd5,  5'd2),
        ctrl_entry(op_rest, 5'd1),
        note_entry(2'd0, 4'd6,  5'd2),
        note_entry(2'd1, 4'd7,  5'd1),
        note_entry(2'd0, 4'd9,  5'd2),
        note_entry(2'd1, 4'd11, 5'd2),
        note_entry(2'd0, 4'd10, 5'd1),
        note_entry(2'd2, 4'd9,  5'd2),
        ctrl_entry(op_end, 5'd0)
    };

endpackage

//--- logic/tone_pkg.sv
package tone_pkg;

    // note code width, code 0 is silence
    localparam int note_w = 4;
    localparam logic [note_w-1:0] note_off = '0;

    // divider counter width, must hold the largest half-period
    localparam int div_w = 5;

    // half-period in clocks per note code
    // scaled far below audio so a few notes fit in a short simulation
    localparam logic [div_w-1:0] half_period [2**note_w] = '{
        5'd18, 5'd17, 5'd16, 5'd15,
        5'd14, 5'd13, 5'd12, 5'd11,
        5'd10, 5'd9,  5'd8,  5'd7,
        5'd6,  5'd5,  5'd4,  5'd3
    };

endpackage

//--- logic/tone_voice.sv
module tone_voice
    import tone_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic [note_w-1:0] note_code,
    input  logic              note_load,
    output logic              wave
);

    logic [div_w-1:0] cnt;
    logic [div_w-1:0] reload;
    logic             silent;

    // counting down to zero takes a full half-period
    assign reload = half_period[note_code] - 1'b1;
    assign silent = (note_code == note_off);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt  <= '0;
            wave <= 1'b0;
        end else if (note_load || silent) begin
            // restart low, phase aligned to the load
            cnt  <= reload;
            wave <= 1'b0;
        end else if (cnt == '0) begin
            cnt  <= reload;
            wave <= ~wave;
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

    // a silenced voice drops its wave on the next edge and keeps it low
    a_silent_low: assert property (@(posedge clk) disable iff (!arst_n)
        silent |=> !wave);

endmodule

//--- logic/voice_mixer.sv
module voice_mixer
    import music_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [num_voices-1:0] wave,
    output logic [1:0]            level
);

    logic [1:0] active;

    always_comb begin
        active = '0;
        for (int v = 0; v < num_voices; v++) begin
            active = active + 2'(wave[v]);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            level <= '0;
        end else begin
            level <= active;
        end
    end

    a_level_range: assert property (@(posedge clk) disable iff (!arst_n)
        level <= 2'(num_voices));

endmodule

//--- music_box.f
logic/tone_pkg.sv
logic/music_pkg.sv
logic/tone_voice.sv
logic/voice_mixer.sv
logic/melody_sequencer.sv
logic/music_box.sv
tests/music_box_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the music_box testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --timescale 1ns/100ps \
        -f music_box.f --top-module music_box_tb -o music_box_sim \
    && ./obj_dir/music_box_sim | tee /dev/stderr | grep -q "No errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- tests/music_box_tb.sv
module music_box_tb
    import music_pkg::*, tone_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    logic                              clk;
    logic                              arst_n;
    logic                              play_req;
    logic                              play_ack;
    logic                              busy;
    logic [num_voices-1:0][note_w-1:0] voice_notes;
    logic [1:0]                        level;

    // expected events, one row per note entry
    int                 ev_offset [$];
    logic [voice_w-1:0] ev_voice [$];
    logic [note_w-1:0]  ev_code [$];
    int                 end_offset;
    int                 first_len;

    int          errors = 0;
    int          errors_at_start = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    string       test_name = "setup";
    int          cycle_cnt = 0;
    int          test_start = 0;
    int          cycle_limit;
    int unsigned rand_state = 93;

    music_box UUT (
        .clk         (clk),
        .arst_n      (arst_n),
        .play_req    (play_req),
        .play_ack    (play_ack),
        .busy        (busy),
        .voice_notes (voice_notes),
        .level       (level)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt - test_start > cycle_limit) begin
            $display("timeout: test %s still running after %0d cycles", test_name, cycle_limit);
            $display("Errors found");
            $finish;
        end
    end

    function automatic int unsigned next_random(input int unsigned range);
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return (rand_state >> 16) % range;
    endfunction

    function automatic void build_events();
        melody_entry_t e;
        int            offset;
        offset = 0;
        for (int i = 0; i < melody_len; i++) begin
            e = melody[idx_w'(i)];
            if (e.note.kind == kind_note) begin
                ev_offset.push_back(offset);
                ev_voice.push_back(e.note.voice);
                ev_code.push_back(e.note.code);
                offset += int'(e.note.steps) * step_ticks;
            end else if (e.ctrl.op == op_end) begin
                end_offset = offset;
                break;
            end else begin
                offset += int'(e.ctrl.steps) * step_ticks;
            end
            if (i == 0) begin
                first_len = offset;
            end
        end
    endfunction

    task automatic start_test(input string name);
        test_name = name;
        errors_at_start = errors;
        test_start = cycle_cnt;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %s: pass", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d mismatches", test_name, errors - errors_at_start);
        end
    endtask

    task automatic report_value(input string what, input logic [31:0] exp_v,
                                input logic [31:0] act_v);
        errors++;
        $display("[FAIL] %s %s: expected %0h, actual %0h", test_name, what, exp_v, act_v);
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("test %s: %s", test_name, what);
    endtask

    // outputs are sampled and inputs driven 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic play_notes();
        logic [num_voices-1:0][note_w-1:0] expected_notes;
        int                                ev;
        expected_notes = '0;
        ev = 0;
        play_req = 1'b1;
        next_cycle();
        for (int off = 0; off < end_offset; off++) begin
            while (ev < ev_offset.size() && ev_offset[ev] == off) begin
                expected_notes[ev_voice[ev]] = ev_code[ev];
                ev++;
            end
            if (voice_notes !== expected_notes) begin
                report_value($sformatf("voice_notes at cycle %0d", off),
                             32'(expected_notes), 32'(voice_notes));
            end
            if (busy !== 1'b1) begin
                report_value($sformatf("busy at cycle %0d", off), 1, 32'(busy));
            end
            if (play_ack !== 1'b0) begin
                report_value($sformatf("play_ack at cycle %0d", off), 0, 32'(play_ack));
            end
            next_cycle();
        end
    endtask

    task automatic end_and_release();
        int hold;
        if (play_ack !== 1'b1) begin
            report_value("play_ack at end entry", 1, 32'(play_ack));
        end
        if (busy !== 1'b0) begin
            report_value("busy at end entry", 0, 32'(busy));
        end
        if (voice_notes !== '0) begin
            report_value("voice_notes at end entry", 0, 32'(voice_notes));
        end
        hold = next_random(4);
        repeat (hold) begin
            next_cycle();
            if (play_ack !== 1'b1) begin
                report_value("play_ack while request held", 1, 32'(play_ack));
            end
        end
        play_req = 1'b0;
        next_cycle();
        if (play_ack !== 1'b0) begin
            report_value("play_ack after release", 0, 32'(play_ack));
        end
    endtask

    // entry 0 is the only voice sounding, so level follows its wave
    task automatic measure_pitch();
        logic [note_w-1:0] code;
        logic [1:0]        prev_level;
        int                hp;
        int                last_change;
        int                intervals;
        code = ev_code[0];
        hp = int'(half_period[code]);
        last_change = -1;
        intervals = 0;
        play_req = 1'b1;
        next_cycle();
        prev_level = level;
        for (int off = 0; off < first_len; off++) begin
            if (level > 2'd1) begin
                report_value("level on solo entry", 1, 32'(level));
            end else if (level != prev_level) begin
                if (last_change >= 0) begin
                    intervals++;
                    if (off - last_change != hp) begin
                        report_value($sformatf("half-period of code %0d", code), hp,
                                     off - last_change);
                    end
                end
                last_change = off;
            end
            prev_level = level;
            next_cycle();
        end
        if (intervals < 2) begin
            report_problem("too few wave edges on the solo entry");
        end
        play_req = 1'b0;
        next_cycle();
    endtask

    task automatic abort_midway();
        int wait_cycles;
        wait_cycles = step_ticks + next_random(end_offset - 2 * step_ticks);
        play_req = 1'b1;
        next_cycle();
        repeat (wait_cycles) next_cycle();
        if (busy !== 1'b1) begin
            report_value("busy before abort", 1, 32'(busy));
        end
        play_req = 1'b0;
        next_cycle();
        if (busy !== 1'b0) begin
            report_value("busy after abort", 0, 32'(busy));
        end
        if (voice_notes !== '0) begin
            report_value("voice_notes after abort", 0, 32'(voice_notes));
        end
        repeat (2 * step_ticks) begin
            if (play_ack !== 1'b0) begin
                report_value("play_ack after abort", 0, 32'(play_ack));
            end
            next_cycle();
        end
    endtask

    initial begin
        play_req = 1'b0;
        arst_n = 1'b0;
        build_events();
        cycle_limit = 2 * end_offset + 200;
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;

        start_test("reset_state");
        if (play_ack !== 1'b0) begin
            report_value("play_ack", 0, 32'(play_ack));
        end
        if (busy !== 1'b0) begin
            report_value("busy", 0, 32'(busy));
        end
        if (level !== 2'd0) begin
            report_value("level", 0, 32'(level));
        end
        if (voice_notes !== '0) begin
            report_value("voice_notes", 0, 32'(voice_notes));
        end
        finish_test();

        start_test("note_sequence");
        play_notes();
        finish_test();

        start_test("handshake");
        end_and_release();
        finish_test();

        start_test("pitch");
        measure_pitch();
        finish_test();

        start_test("second_play");
        repeat (next_random(20) + 1) begin
            next_cycle();
            if (play_ack !== 1'b0) begin
                report_value("play_ack between plays", 0, 32'(play_ack));
            end
            if (busy !== 1'b0) begin
                report_value("busy between plays", 0, 32'(busy));
            end
        end
        play_notes();
        end_and_release();
        finish_test();

        start_test("abort");
        abort_midway();
        finish_test();

        $display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
